// ==== rtl/mastermind_pkg.sv ====
`default_nettype none

package mastermind_pkg;

	// Board geometry
	localparam int PINS        = 4;
	localparam int PIN_COLORS  = 6;
	localparam int MAX_GUESSES = 10;

	localparam int PIN_W    = 3;
	localparam int POS_W    = 2;
	localparam int ROW_W    = 4;
	localparam int CURSOR_W = $clog2(PINS + 2); // Exit, guess and one slot per tile

	// Board RAM layout
	localparam int ADDR_W     = 6;
	localparam int DATA_W     = 8;
	localparam int HINTS_BASE = 40; // Yellow at +2r, green at +2r+1

	// Buttons
	localparam int NUM_BTNS     = 5;
	localparam int BTN_LEFT     = 0;
	localparam int BTN_RIGHT    = 1;
	localparam int BTN_UP       = 2;
	localparam int BTN_DOWN     = 3;
	localparam int BTN_ENTER    = 4;
	localparam int DEBOUNCE_LEN = 16;
	localparam int DEB_CNT_W    = $clog2(DEBOUNCE_LEN);

	// Secret draw
	localparam int RNG_W                  = 32;
	localparam int RNG_MOD_W              = 8; // Low byte feeds the modulo
	localparam logic [RNG_W-1:0] RNG_SEED = 32'h0000_0001;
	localparam logic [RNG_W-1:0] RNG_POLY = 32'h8020_0003;

	// Scoring sequence: pins, all pairs, then two count writes
	localparam int SCORE_STEPS = PINS + PINS * PINS + 2;
	localparam int SEQ_W       = $clog2(SCORE_STEPS);

	typedef logic [PINS-1:0][PIN_W-1:0] guess_t;

	typedef enum logic [1:0] {
		MENU     = 2'd0,
		GENERATE = 2'd1,
		GAME     = 2'd2
	} game_state_t;

endpackage

`default_nettype wire

// ==== rtl/game_ifs.sv ====
`timescale 1ns/1ps
`default_nettype none

// One-cycle press pulses, already debounced
interface press_events_if;
	logic left;
	logic right;
	logic up;
	logic down;
	logic enter;

	modport source (
		output left,
		output right,
		output up,
		output down,
		output enter
	);

	modport sink (
		input left,
		input right,
		input up,
		input down,
		input enter
	);
endinterface

// Scoring request from the game FSM to the scorer
interface score_req_if import mastermind_pkg::*; ;
	logic             start;  // One cycle, only while busy is low
	logic [ROW_W-1:0] row;
	guess_t           guess;
	guess_t           secret;
	logic             busy;

	modport requester (
		output start,
		output row,
		output guess,
		output secret,
		input  busy
	);

	modport scorer (
		input  start,
		input  row,
		input  guess,
		input  secret,
		output busy
	);
endinterface

`default_nettype wire

// ==== rtl/button_conditioner.sv ====
`timescale 1ns/1ps
`default_nettype none

module button_conditioner import mastermind_pkg::*; (
	input  logic                CLK_PLL,
	input  logic                reset,
	input  logic [NUM_BTNS-1:0] raw_n,  // Active low
	press_events_if.source      ev
);

	logic [NUM_BTNS-1:0]                pressed_raw;
	logic [NUM_BTNS-1:0]                sample;   // Last raw level seen
	logic [NUM_BTNS-1:0][DEB_CNT_W-1:0] stable_cnt;
	logic [NUM_BTNS-1:0]                level;    // Debounced, 1 = pressed
	logic [NUM_BTNS-1:0]                level_d;
	logic [NUM_BTNS-1:0]                pulse;

	assign pressed_raw = ~raw_n;

	always_ff @(posedge CLK_PLL) begin
		if (reset) begin
			sample     <= '0;
			stable_cnt <= '0;
			level      <= '0;
			level_d    <= '0;
			pulse      <= '0;
		end else begin
			for (int i = 0; i < NUM_BTNS; i++) begin
				if (pressed_raw[i] != sample[i]) begin
					// Any change restarts the stability window
					sample[i]     <= pressed_raw[i];
					stable_cnt[i] <= '0;
				end else if (stable_cnt[i] == DEB_CNT_W'(DEBOUNCE_LEN - 1)) begin
					level[i] <= sample[i];
				end else begin
					stable_cnt[i] <= stable_cnt[i] + 1'b1;
				end
			end
			level_d <= level;
			pulse   <= level & ~level_d; // Rising edge of pressed level
		end
	end

	assign ev.left  = pulse[BTN_LEFT];
	assign ev.right = pulse[BTN_RIGHT];
	assign ev.up    = pulse[BTN_UP];
	assign ev.down  = pulse[BTN_DOWN];
	assign ev.enter = pulse[BTN_ENTER];

endmodule

`default_nettype wire

// ==== rtl/secret_generator.sv ====
`timescale 1ns/1ps
`default_nettype none

module secret_generator import mastermind_pkg::*; (
	input  logic             CLK_PLL,
	input  logic             reset,
	input  logic             draw,
	output logic [PIN_W-1:0] color
);

	logic [RNG_W-1:0] lfsr;
	logic [RNG_W-1:0] lfsr_next;

	// Galois step: shift right, fold polynomial in on a dropped one
	assign lfsr_next = (lfsr >> 1) ^ (lfsr[0] ? RNG_POLY : '0);

	// Colour of the state this draw moves to
	assign color = PIN_W'(lfsr_next[RNG_MOD_W-1:0] % RNG_MOD_W'(PIN_COLORS));

	always_ff @(posedge CLK_PLL) begin
		if (reset) begin
			lfsr <= RNG_SEED;
		end else if (draw) begin
			lfsr <= lfsr_next; // Only advances on a draw
		end
	end

endmodule

`default_nettype wire

// ==== rtl/game_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module game_control import mastermind_pkg::*; (
	input  logic             CLK_PLL,
	input  logic             reset,
	press_events_if.sink     ev,
	output logic             draw,
	input  logic [PIN_W-1:0] color,
	score_req_if.requester   req,
	output logic             led_pending,
	output logic             led_scored
);

	game_state_t         state;
	guess_t              secret;
	guess_t              guess;
	logic [POS_W-1:0]    gen_idx;   // Next secret pin to draw
	logic [CURSOR_W-1:0] cursor;    // 0 exit, 1 guess, 2.. tiles
	logic [ROW_W-1:0]    row;
	logic                pending;
	logic                scored;
	logic                busy_q;
	logic [POS_W-1:0]    tile;

	assign tile = POS_W'(cursor - CURSOR_W'(2));

	assign draw = (state == GENERATE);

	// Fire as soon as the scorer is free
	assign req.start  = pending && !req.busy;
	assign req.row    = row;
	assign req.guess  = guess;
	assign req.secret = secret;

	assign led_pending = pending;
	assign led_scored  = scored;

	always_ff @(posedge CLK_PLL) begin
		if (state == GENERATE) begin
			secret[gen_idx] <= color;
		end
	end

	always_ff @(posedge CLK_PLL) begin
		if (reset) begin
			state   <= MENU;
			gen_idx <= '0;
			cursor  <= '0;
			row     <= '0;
			guess   <= '0;
			pending <= 1'b0;
			scored  <= 1'b0;
			busy_q  <= 1'b0;
		end else begin
			busy_q <= req.busy;

			if (req.start) begin
				pending <= 1'b0;
			end
			// Scorer just finished and nothing else is queued
			if (busy_q && !req.busy && !pending && state == GAME) begin
				scored <= 1'b1;
			end

			case (state)
				MENU: begin
					if (ev.enter) begin
						state   <= GENERATE;
						gen_idx <= '0;
					end
				end

				GENERATE: begin
					gen_idx <= gen_idx + 1'b1;
					if (gen_idx == POS_W'(PINS - 1)) begin
						state   <= GAME;
						guess   <= '0;
						cursor  <= '0;
						row     <= '0;
						pending <= 1'b1; // Row 0 gets scored right away
						scored  <= 1'b0;
					end
				end

				GAME: begin
					if (ev.right && cursor != CURSOR_W'(PINS + 1)) begin
						cursor <= cursor + 1'b1;
					end else if (ev.left && cursor != '0) begin
						cursor <= cursor - 1'b1;
					end

					if (ev.enter) begin
						if (cursor == '0) begin
							state   <= MENU;
							pending <= 1'b0;
							scored  <= 1'b0;
						end else if (scored) begin
							if (cursor == CURSOR_W'(1)) begin
								// Commit, guess stays as the start of the next row
								if (row != ROW_W'(MAX_GUESSES - 1)) begin
									row <= row + 1'b1;
								end
							end else if (guess[tile] == PIN_W'(PIN_COLORS - 1)) begin
								guess[tile] <= '0;
							end else begin
								guess[tile] <= guess[tile] + 1'b1;
							end
							pending <= 1'b1;
							scored  <= 1'b0;
						end
					end
				end

				default: state <= MENU;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/guess_scorer.sv ====
`timescale 1ns/1ps
`default_nettype none

module guess_scorer import mastermind_pkg::*; (
	input  logic              CLK_PLL,
	input  logic              reset,
	score_req_if.scorer       req,
	output logic              we,
	output logic [ADDR_W-1:0] waddr,
	output logic [DATA_W-1:0] wdata
);

	logic               busy;
	logic [SEQ_W-1:0]   seq;
	logic [ROW_W-1:0]   row_q;
	guess_t             guess_q;
	guess_t             secret_q;
	logic [PINS-1:0]    used_g;    // Guess pins already counted
	logic [PINS-1:0]    used_s;    // Secret pins already counted
	logic [POS_W:0]     green;
	logic [POS_W:0]     yellow;
	logic [POS_W-1:0]   pin;
	logic [2*POS_W-1:0] pair;
	logic [POS_W-1:0]   g_idx;
	logic [POS_W-1:0]   s_idx;
	logic               in_pins;
	logic               in_pairs;
	logic               at_yellow;
	logic               at_green;
	logic [ADDR_W-1:0]  pin_addr;
	logic [ADDR_W-1:0]  hint_addr;

	assign req.busy = busy;

	// Sequence decode
	assign pin       = seq[POS_W-1:0];
	assign pair      = (2 * POS_W)'(seq - SEQ_W'(PINS));
	assign g_idx     = pair[2*POS_W-1:POS_W]; // Guess index is the outer loop
	assign s_idx     = pair[POS_W-1:0];
	assign in_pins   = busy && seq < SEQ_W'(PINS);
	assign in_pairs  = busy && !in_pins && seq < SEQ_W'(PINS + PINS * PINS);
	assign at_yellow = busy && seq == SEQ_W'(SCORE_STEPS - 2);
	assign at_green  = busy && seq == SEQ_W'(SCORE_STEPS - 1);

	assign pin_addr  = ADDR_W'(row_q) * ADDR_W'(PINS) + ADDR_W'(pin);
	assign hint_addr = ADDR_W'(HINTS_BASE) + ADDR_W'({row_q, at_green});

	assign we    = in_pins || at_yellow || at_green;
	assign waddr = in_pins ? pin_addr : hint_addr;
	assign wdata = in_pins ? DATA_W'(guess_q[pin]) : DATA_W'(at_green ? green : yellow);

	always_ff @(posedge CLK_PLL) begin
		if (reset) begin
			busy <= 1'b0;
			seq  <= '0;
		end else if (!busy) begin
			if (req.start) begin
				busy <= 1'b1;
				seq  <= '0;
			end
		end else begin
			seq <= seq + 1'b1;
			if (seq == SEQ_W'(SCORE_STEPS - 1)) begin
				busy <= 1'b0;
			end
		end
	end

	// Request copy and match bookkeeping
	always_ff @(posedge CLK_PLL) begin
		if (!busy && req.start) begin
			row_q    <= req.row;
			guess_q  <= req.guess;
			secret_q <= req.secret;
			used_g   <= '0;
			used_s   <= '0;
			green    <= '0;
			yellow   <= '0;
		end else if (in_pins) begin
			if (guess_q[pin] == secret_q[pin]) begin
				used_g[pin] <= 1'b1;
				used_s[pin] <= 1'b1;
				green       <= green + 1'b1;
			end
		end else if (in_pairs && g_idx != s_idx) begin
			// Colour only, both pins still free
			if (guess_q[g_idx] == secret_q[s_idx] && !used_g[g_idx] && !used_s[s_idx]) begin
				used_g[g_idx] <= 1'b1;
				used_s[s_idx] <= 1'b1;
				yellow        <= yellow + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/board_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module board_ram import mastermind_pkg::*; (
	input  logic              CLK_PLL,
	input  logic              we,
	input  logic [ADDR_W-1:0] waddr,
	input  logic [DATA_W-1:0] wdata,
	input  logic [ADDR_W-1:0] rd_addr,
	output logic [DATA_W-1:0] rd_data
);

	// Pins in 0..39, hint pairs from HINTS_BASE up
	logic [DATA_W-1:0] mem [0:(1 << ADDR_W) - 1] = '{default: '0};

	always_ff @(posedge CLK_PLL) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
		rd_data <= mem[rd_addr]; // Data one cycle after the address
	end

endmodule

`default_nettype wire

// ==== rtl/mastermind_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mastermind_top import mastermind_pkg::*; (
	input  logic              CLK_PLL,
	input  logic              reset,
	input  logic              btn_left,   // Raw, active low
	input  logic              btn_right,
	input  logic              btn_up,
	input  logic              btn_down,
	input  logic              btn_enter,
	input  logic [ADDR_W-1:0] rd_addr,
	output logic [DATA_W-1:0] rd_data,
	output logic              led_pending,
	output logic              led_scoring,
	output logic              led_scored
);

	logic [NUM_BTNS-1:0] raw_n;
	logic                draw;
	logic [PIN_W-1:0]    color;
	logic                we;
	logic [ADDR_W-1:0]   waddr;
	logic [DATA_W-1:0]   wdata;

	press_events_if ev_if ();
	score_req_if    req_if ();

	assign raw_n[BTN_LEFT]  = btn_left;
	assign raw_n[BTN_RIGHT] = btn_right;
	assign raw_n[BTN_UP]    = btn_up;
	assign raw_n[BTN_DOWN]  = btn_down;
	assign raw_n[BTN_ENTER] = btn_enter;

	assign led_scoring = req_if.busy;

	button_conditioner u_buttons (
		.CLK_PLL (CLK_PLL),
		.reset   (reset),
		.raw_n   (raw_n),
		.ev      (ev_if.source)
	);

	secret_generator u_secret (
		.CLK_PLL (CLK_PLL),
		.reset   (reset),
		.draw    (draw),
		.color   (color)
	);

	game_control u_control (
		.CLK_PLL     (CLK_PLL),
		.reset       (reset),
		.ev          (ev_if.sink),
		.draw        (draw),
		.color       (color),
		.req         (req_if.requester),
		.led_pending (led_pending),
		.led_scored  (led_scored)
	);

	guess_scorer u_scorer (
		.CLK_PLL (CLK_PLL),
		.reset   (reset),
		.req     (req_if.scorer),
		.we      (we),
		.waddr   (waddr),
		.wdata   (wdata)
	);

	board_ram u_ram (
		.CLK_PLL (CLK_PLL),
		.we      (we),
		.waddr   (waddr),
		.wdata   (wdata),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

endmodule

`default_nettype wire

// ==== sim/tb_mastermind.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mastermind import mastermind_pkg::*; ();

	localparam logic [31:0] RAND_SEED = 32'h27a2faec;
	localparam logic [31:0] RAND_POLY = 32'hb4bc_d35c;
	localparam int N_CHANGES     = 6;
	localparam int SCORE_LEN     = PINS + PINS * PINS + 2; // Pins, pairs, two hint writes
	localparam int SCORE_WAIT    = 4 * SCORE_STEPS;
	localparam int PRESS_CYCLES  = 4 * DEBOUNCE_LEN; // Low then high, 2x window each
	localparam int MAX_PRESSES   = 80;
	localparam int RAM_SWEEP     = (1 << ADDR_W) + 2;
	localparam int MAX_SWEEPS    = 24;
	localparam int TIMEOUT_CYCLES = 2 * (MAX_PRESSES * PRESS_CYCLES + MAX_SWEEPS * RAM_SWEEP) + 100;

	logic                CLK_PLL;
	logic                reset;
	logic [NUM_BTNS-1:0] btn_n;
	logic [ADDR_W-1:0]   rd_addr;
	logic [DATA_W-1:0]   rd_data;
	logic                led_pending;
	logic                led_scoring;
	logic                led_scored;

	// Read pipeline towards the comparing process
	logic              rd_valid;
	logic [DATA_W-1:0] rd_expect;
	logic              cmp_valid = 1'b0;
	logic [ADDR_W-1:0] cmp_addr;
	logic [DATA_W-1:0] cmp_data;

	logic [DATA_W-1:0] exp_mem [0:(1 << ADDR_W) - 1]; // Expected board contents
	logic [31:0]       rng_state;
	logic [31:0]       model_lfsr;
	guess_t            model_guess;
	guess_t            model_secret;
	int                cursor;
	int                row;
	int                errors;
	int                err_base;
	int                checks;
	int                test_num;
	int                cycles = 0;
	logic              seen_pending;
	int                busy_len  = 0; // Cycles of the current scoring run
	int                busy_runs = 0;
	int                runs_expected;
	logic              pending_q = 1'b0;

	mastermind_top dut (
		.CLK_PLL     (CLK_PLL),
		.reset       (reset),
		.btn_left    (btn_n[BTN_LEFT]),
		.btn_right   (btn_n[BTN_RIGHT]),
		.btn_up      (btn_n[BTN_UP]),
		.btn_down    (btn_n[BTN_DOWN]),
		.btn_enter   (btn_n[BTN_ENTER]),
		.rd_addr     (rd_addr),
		.rd_data     (rd_data),
		.led_pending (led_pending),
		.led_scoring (led_scoring),
		.led_scored  (led_scored)
	);

	always #5 CLK_PLL = ~CLK_PLL;

	always @(posedge CLK_PLL) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("test failed");
			$finish;
		end
	end

	// Secret generator model: shift right, fold polynomial in on a dropped one
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return (s >> 1) ^ (s[0] ? RNG_POLY : 32'h0);
	endfunction

	// Stimulus bits, one Galois step per bit taken
	function automatic int unsigned rand_bits(input int n);
		int unsigned v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			rng_state = (rng_state >> 1) ^ (rng_state[0] ? RAND_POLY : 32'h0);
			v = (v << 1) | 32'(rng_state[0]);
		end
		return v;
	endfunction

	// Green by position, yellow from shared colour counts minus green
	function automatic void score(input guess_t g, input guess_t s,
		output int green, output int yellow);
		int cnt_g [1 << PIN_W];
		int cnt_s [1 << PIN_W];
		int common;
		green  = 0;
		common = 0;
		for (int c = 0; c < (1 << PIN_W); c++) begin
			cnt_g[c] = 0;
			cnt_s[c] = 0;
		end
		for (int i = 0; i < PINS; i++) begin
			if (g[i] == s[i]) begin
				green++;
			end
			cnt_g[g[i]]++;
			cnt_s[s[i]]++;
		end
		for (int c = 0; c < (1 << PIN_W); c++) begin
			common += (cnt_g[c] < cnt_s[c]) ? cnt_g[c] : cnt_s[c];
		end
		yellow = common - green;
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			$display("** Error at %0t: %s = %0d, expected %0d", $time, name, actual, expected);
			errors++;
		end
	endtask

	always @(posedge CLK_PLL) begin
		cmp_valid <= rd_valid;
		cmp_addr  <= rd_addr;
		cmp_data  <= rd_expect;
	end

	// Read data is registered, so compare one cycle after the address
	always @(negedge CLK_PLL) begin
		if (cmp_valid) begin
			check_value($sformatf("rd_data[%0d]", cmp_addr), 32'(rd_data), 32'(cmp_data));
		end
	end

	// Each scoring run follows a one-cycle request and lasts the whole sequence
	always @(negedge CLK_PLL) begin
		if (led_scoring) begin
			if (busy_len == 0) begin
				check_value("led_pending", 32'(pending_q), 32'd1);
			end
			busy_len <= busy_len + 1;
		end else if (busy_len != 0) begin
			check_value("led_scoring", 32'(busy_len), 32'(SCORE_LEN));
			busy_runs <= busy_runs + 1;
			busy_len  <= 0;
		end
		pending_q <= led_pending;
	end

	task automatic press(input int b);
		@(negedge CLK_PLL);
		btn_n[b] = 1'b0;
		repeat (2 * DEBOUNCE_LEN) @(negedge CLK_PLL);
		btn_n[b] = 1'b1;
		repeat (2 * DEBOUNCE_LEN) @(negedge CLK_PLL);
	endtask

	task automatic move_to(input int target);
		while (cursor < target) begin
			press(BTN_RIGHT);
			cursor++;
		end
		while (cursor > target) begin
			press(BTN_LEFT);
			cursor--;
		end
	endtask

	task automatic wait_scored();
		int n;
		n = 0;
		runs_expected++;
		while (!led_scored && n < SCORE_WAIT) begin
			@(negedge CLK_PLL);
			n++;
		end
		if (!led_scored) begin
			$display("Error at %0t: led_scored did not rise within %0d cycles", $time, SCORE_WAIT);
			errors++;
		end
	endtask

	task automatic draw_secret();
		for (int i = 0; i < PINS; i++) begin
			model_lfsr      = lfsr_step(model_lfsr);
			model_secret[i] = PIN_W'(model_lfsr[7:0] % 8'(PIN_COLORS));
		end
	endtask

	task automatic update_row(input int r);
		int g;
		int y;
		for (int i = 0; i < PINS; i++) begin
			exp_mem[PINS * r + i] = DATA_W'(model_guess[i]);
		end
		score(model_guess, model_secret, g, y);
		exp_mem[HINTS_BASE + 2 * r]     = DATA_W'(y);
		exp_mem[HINTS_BASE + 2 * r + 1] = DATA_W'(g);
	endtask

	// Sweep the whole board through the read port
	task automatic check_ram();
		for (int a = 0; a < (1 << ADDR_W); a++) begin
			@(negedge CLK_PLL);
			rd_addr   = ADDR_W'(a);
			rd_expect = exp_mem[a];
			rd_valid  = 1'b1;
		end
		@(negedge CLK_PLL);
		rd_valid = 1'b0;
		@(negedge CLK_PLL);
	endtask

	task automatic apply_change();
		int tile;
		int enters;
		tile   = int'(rand_bits(2));
		enters = 1 + int'(rand_bits(1));
		move_to(2 + tile);
		for (int k = 0; k < enters; k++) begin
			press(BTN_ENTER);
			if (model_guess[tile] == PIN_W'(PIN_COLORS - 1)) begin
				model_guess[tile] = '0; // Wraps back to the first colour
			end else begin
				model_guess[tile] = model_guess[tile] + 1'b1;
			end
			wait_scored();
			update_row(row);
			check_ram();
		end
	endtask

	task automatic end_test(input string name);
		$display("Test %0d %s: %0d errors", test_num, name, errors - err_base);
		err_base = errors;
		test_num++;
	endtask

	initial begin
		CLK_PLL       = 1'b0;
		reset         = 1'b1;
		btn_n         = '1;
		rd_addr       = '0;
		rd_valid      = 1'b0;
		rd_expect     = '0;
		rng_state     = RAND_SEED;
		model_lfsr    = RNG_SEED;
		model_guess   = '0;
		model_secret  = '0;
		cursor        = 0;
		row           = 0;
		errors        = 0;
		err_base      = 0;
		checks        = 0;
		test_num      = 1;
		runs_expected = 0;
		for (int a = 0; a < (1 << ADDR_W); a++) begin
			exp_mem[a] = '0;
		end
		repeat (5) @(posedge CLK_PLL);
		@(negedge CLK_PLL);
		reset = 1'b0;

		check_value("led_pending", 32'(led_pending), 32'd0);
		check_value("led_scoring", 32'(led_scoring), 32'd0);
		check_value("led_scored", 32'(led_scored), 32'd0);
		check_ram();
		end_test("reset state");

		press(BTN_ENTER); // Menu to game
		draw_secret();
		wait_scored();
		update_row(0);
		check_value("led_pending", 32'(led_pending), 32'd0);
		check_value("led_scored", 32'(led_scored), 32'd1);
		check_ram();
		end_test("new game row 0");

		for (int n = 0; n < N_CHANGES; n++) begin
			apply_change();
		end
		end_test("random tile changes");

		move_to(1);
		press(BTN_ENTER);
		if (row < MAX_GUESSES - 1) begin
			row++;
		end
		wait_scored();
		update_row(row);
		check_ram();
		apply_change();
		apply_change();
		end_test("commit to row 1");

		move_to(2);
		seen_pending = 1'b0;
		@(negedge CLK_PLL);
		btn_n[BTN_ENTER] = 1'b0;
		repeat (DEBOUNCE_LEN - 4) begin
			@(negedge CLK_PLL);
			seen_pending = seen_pending | led_pending;
		end
		btn_n[BTN_ENTER] = 1'b1;
		repeat (3 * DEBOUNCE_LEN) begin
			@(negedge CLK_PLL);
			seen_pending = seen_pending | led_pending;
		end
		check_value("led_pending", 32'(seen_pending), 32'd0);
		check_ram();
		end_test("short glitch ignored");

		move_to(0);
		press(BTN_ENTER); // Exit to menu
		check_value("led_scored", 32'(led_scored), 32'd0);
		press(BTN_ENTER);
		draw_secret(); // Next four draws
		model_guess = '0;
		cursor      = 0;
		row         = 0;
		wait_scored();
		update_row(0);
		check_ram();
		check_value("led_scoring runs", 32'(busy_runs), 32'(runs_expected));
		end_test("exit and fresh secret");

		repeat (2) @(negedge CLK_PLL);
		$display("Summary: %0d tests, %0d checks, %0d errors", test_num - 1, checks, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
rtl/mastermind_pkg.sv
rtl/game_ifs.sv
rtl/button_conditioner.sv
rtl/secret_generator.sv
rtl/game_control.sv
rtl/guess_scorer.sv
rtl/board_ram.sv
rtl/mastermind_top.sv
sim/tb_mastermind.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_mastermind
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the pass message in the simulator output
run: build
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'test passed'

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
